//--- source/bmc_sensor_pkg.sv
package bmc_sensor_pkg;

  localparam int ADC_WIDTH     = 12;
  localparam int CHANNEL_WIDTH = 5;
  localparam int NUM_CHANNELS  = 8;  // channels 8..31 of the sequencer are not checked

  // one entry per channel, listed from channel 7 down to channel 0
  typedef logic [NUM_CHANNELS-1:0][ADC_WIDTH-1:0] threshold_table_t;

  typedef struct packed {
    logic                     strobe;   // result is valid for this cycle only
    logic [CHANNEL_WIDTH-1:0] channel;
    logic [ADC_WIDTH-1:0]     result;
  } adc_sample_t;

  typedef struct packed {
    logic [NUM_CHANNELS-1:0] in_range;   // last verdict per channel, held between samples
    logic                    soft_viol;  // one cycle pulse
    logic                    hard_viol;  // one cycle pulse
  } health_t;

  // rails 0..5 are scaled voltages, channels 6 and 7 are the board temperature sensors
  localparam threshold_table_t HARD_LOW = '{
    12'd100,  12'd100,  12'd1000, 12'd1500,
    12'd1800, 12'd2200, 12'd2400, 12'd2600
  };

  localparam threshold_table_t SOFT_LOW = '{
    12'd200,  12'd200,  12'd1100, 12'd1650,
    12'd1950, 12'd2400, 12'd2600, 12'd2800
  };

  localparam threshold_table_t SOFT_HIGH = '{
    12'd3000, 12'd3000, 12'd1300, 12'd1950,
    12'd2250, 12'd2800, 12'd3000, 12'd3200
  };

  localparam threshold_table_t HARD_HIGH = '{
    12'd3600, 12'd3600, 12'd1400, 12'd2100,
    12'd2400, 12'd3000, 12'd3200, 12'd3400
  };

  // the 12V, 5V and 3V3 standby readings must be healthy before the supply is switched on
  localparam logic [NUM_CHANNELS-1:0] POWERUP_MASK = 8'b0000_0111;

endpackage

//--- source/bmc_power_pkg.sv
package bmc_power_pkg;

  typedef enum logic [1:0] {
    PWR_OFF      = 2'd0,
    PWR_STARTING = 2'd1,  // supply enabled, waiting for supply good
    PWR_ON       = 2'd2
  } power_state_t;

  // encoding matches the reference no_power_cause field
  typedef enum logic [1:0] {
    CAUSE_NONE     = 2'd0,
    CAUSE_BUTTON   = 2'd1,
    CAUSE_FAULT    = 2'd2,
    CAUSE_ATX_FAIL = 2'd3
  } power_cause_t;

  typedef struct packed {
    power_state_t state;
    power_cause_t cause;  // reason for the last transition to off
  } power_status_t;

  // the button must hold one level this many cycles to be accepted
  localparam int DEBOUNCE_CYCLES = 16;

  // cycles allowed between ps_on and supply good
  localparam int ATX_TIMEOUT = 64;

  // blink counter taps, the fault blink is the faster one
  localparam int BLINK_BIT      = 4;
  localparam int SLOW_BLINK_BIT = 6;

endpackage

//--- source/button_debouncer.sv
`timescale 1ns/1ps

module button_debouncer (
  input  logic gclk40,
  input  logic hard_reset,
  input  logic button_n_i,
  output logic press_o
);

  logic [1:0] sync_q;  // two flop synchronizer, bit 1 is the safe copy
  logic       level_q;  // filtered level, high means released
  logic [$clog2(bmc_power_pkg::DEBOUNCE_CYCLES+1)-1:0] count_q;
  logic       settle;
  logic       press_q;

  // the synchronized input has differed from the filtered level long enough
  assign settle = (sync_q[1] != level_q) &&
                  (count_q == bmc_power_pkg::DEBOUNCE_CYCLES - 1);

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      sync_q  <= 2'b11;  // treat the button as released
      level_q <= 1'b1;
      count_q <= '0;
      press_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], button_n_i};
      press_q <= settle && !sync_q[1];  // only the change to pressed gives a pulse
      if (sync_q[1] == level_q) begin
        count_q <= '0;  // a bounce back restarts the count
      end else if (settle) begin
        level_q <= sync_q[1];
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign press_o = press_q;

endmodule

//--- source/level_checker.sv
`timescale 1ns/1ps

module level_checker (
  input  logic                        gclk40,
  input  logic                        hard_reset,
  input  bmc_sensor_pkg::adc_sample_t sample_i,
  output bmc_sensor_pkg::health_t     health_o
);

  logic [$clog2(bmc_sensor_pkg::NUM_CHANNELS)-1:0] ch_idx;
  logic                                 ch_valid;
  logic [bmc_sensor_pkg::ADC_WIDTH-1:0] hard_low;
  logic [bmc_sensor_pkg::ADC_WIDTH-1:0] soft_low;
  logic [bmc_sensor_pkg::ADC_WIDTH-1:0] soft_high;
  logic [bmc_sensor_pkg::ADC_WIDTH-1:0] hard_high;
  logic                                 in_window;
  logic                                 out_hard;
  bmc_sensor_pkg::health_t              health_q;

  assign ch_idx = sample_i.channel[$clog2(bmc_sensor_pkg::NUM_CHANNELS)-1:0];

  // channels beyond the table are sampled by the sequencer but never checked
  assign ch_valid = sample_i.strobe &&
                    (sample_i.channel < bmc_sensor_pkg::NUM_CHANNELS);

  always_comb begin
    hard_low  = bmc_sensor_pkg::HARD_LOW[ch_idx];
    soft_low  = bmc_sensor_pkg::SOFT_LOW[ch_idx];
    soft_high = bmc_sensor_pkg::SOFT_HIGH[ch_idx];
    hard_high = bmc_sensor_pkg::HARD_HIGH[ch_idx];
  end

  // the two limits of each window are inclusive
  assign in_window = (sample_i.result >= soft_low) && (sample_i.result <= soft_high);
  assign out_hard  = (sample_i.result < hard_low) || (sample_i.result > hard_high);

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      health_q <= '0;  // nothing is known to be in range yet
    end else begin
      // between the soft and the hard limit is a soft violation only
      health_q.soft_viol <= ch_valid && !in_window && !out_hard;
      health_q.hard_viol <= ch_valid && out_hard;
      if (ch_valid) begin
        health_q.in_range[ch_idx] <= in_window;
      end
    end
  end

  assign health_o = health_q;

endmodule

//--- source/power_manager.sv
`timescale 1ns/1ps

module power_manager (
  input  logic                         gclk40,
  input  logic                         hard_reset,
  input  logic                         press_i,
  input  bmc_sensor_pkg::health_t      health_i,
  input  logic                         atx_pwr_ok_i,
  output logic                         atx_ps_on_n_o,
  output logic                         power_ok_o,
  output bmc_power_pkg::power_cause_t  no_power_cause_o,
  output logic [1:0]                   chs_led_n_o
);

  bmc_power_pkg::power_status_t status_q;
  bmc_power_pkg::power_status_t status_d;
  logic [$clog2(bmc_power_pkg::ATX_TIMEOUT+1)-1:0] timer_q;
  logic [$clog2(bmc_power_pkg::ATX_TIMEOUT+1)-1:0] timer_d;
  logic [bmc_power_pkg::SLOW_BLINK_BIT:0] blink_q;
  logic [bmc_power_pkg::SLOW_BLINK_BIT:0] blink_d;
  logic       soft_seen_q;
  logic       soft_seen_d;
  logic       powerup_ok;
  logic       start_req;
  logic       bad_cause;
  logic       power_led;
  logic       action_led;
  logic [1:0] led_n_q;

  // every rail in the mask has to report in range
  assign powerup_ok = (health_i.in_range & bmc_sensor_pkg::POWERUP_MASK) ==
                      bmc_sensor_pkg::POWERUP_MASK;

  assign start_req = (status_q.state == bmc_power_pkg::PWR_OFF) && press_i && powerup_ok;

  always_comb begin
    status_d = status_q;
    timer_d  = timer_q;
    case (status_q.state)
      bmc_power_pkg::PWR_OFF: begin
        if (start_req) begin
          status_d.state = bmc_power_pkg::PWR_STARTING;
          status_d.cause = bmc_power_pkg::CAUSE_NONE;
          timer_d        = '0;
        end
      end
      bmc_power_pkg::PWR_STARTING: begin
        if (atx_pwr_ok_i) begin
          status_d.state = bmc_power_pkg::PWR_ON;
        end else if (timer_q == bmc_power_pkg::ATX_TIMEOUT - 1) begin
          status_d.state = bmc_power_pkg::PWR_OFF;  // supply never came good
          status_d.cause = bmc_power_pkg::CAUSE_ATX_FAIL;
        end else begin
          timer_d = timer_q + 1'b1;
        end
      end
      bmc_power_pkg::PWR_ON: begin
        // a fault outranks a lost supply, which outranks the button
        if (health_i.hard_viol) begin
          status_d.state = bmc_power_pkg::PWR_OFF;
          status_d.cause = bmc_power_pkg::CAUSE_FAULT;
        end else if (!atx_pwr_ok_i) begin
          status_d.state = bmc_power_pkg::PWR_OFF;
          status_d.cause = bmc_power_pkg::CAUSE_ATX_FAIL;
        end else if (press_i) begin
          status_d.state = bmc_power_pkg::PWR_OFF;
          status_d.cause = bmc_power_pkg::CAUSE_BUTTON;
        end
      end
      default: begin
        status_d.state = bmc_power_pkg::PWR_OFF;
      end
    endcase
  end

  // soft violations are remembered until the next power-up attempt
  assign soft_seen_d = start_req ? 1'b0 : (soft_seen_q | health_i.soft_viol);

  assign blink_d = blink_q + 1'b1;

  // LED drive is taken from the next values so it lines up with the state register
  assign bad_cause = (status_d.cause == bmc_power_pkg::CAUSE_FAULT) ||
                     (status_d.cause == bmc_power_pkg::CAUSE_ATX_FAIL);

  always_comb begin
    if (status_d.state == bmc_power_pkg::PWR_ON) begin
      power_led  = 1'b1;
      action_led = soft_seen_d;
    end else begin
      power_led  = bad_cause ? blink_d[bmc_power_pkg::BLINK_BIT] : 1'b0;
      action_led = blink_d[bmc_power_pkg::SLOW_BLINK_BIT];  // idle heartbeat
    end
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      status_q.state <= bmc_power_pkg::PWR_OFF;
      status_q.cause <= bmc_power_pkg::CAUSE_NONE;
      timer_q        <= '0;
      blink_q        <= '0;
      soft_seen_q    <= 1'b0;
      led_n_q        <= 2'b00;  // lamp test, both LEDs lit during reset
    end else begin
      status_q    <= status_d;
      timer_q     <= timer_d;
      blink_q     <= blink_d;
      soft_seen_q <= soft_seen_d;
      led_n_q     <= ~{action_led, power_led};
    end
  end

  // the supply is enabled in every state except off
  assign atx_ps_on_n_o    = (status_q.state == bmc_power_pkg::PWR_OFF);
  assign power_ok_o       = (status_q.state == bmc_power_pkg::PWR_ON);
  assign no_power_cause_o = status_q.cause;
  assign chs_led_n_o      = led_n_q;

endmodule

//--- source/power_supervisor.sv
`timescale 1ns/1ps

module power_supervisor (
  input  logic                        gclk40,
  input  logic                        hard_reset,
  input  bmc_sensor_pkg::adc_sample_t adc_sample_i,
  input  logic                        chs_powerdown_n_i,
  input  logic                        atx_pwr_ok_i,
  output logic                        atx_ps_on_n_o,
  output logic                        power_ok_o,
  output bmc_power_pkg::power_cause_t no_power_cause_o,
  output logic [1:0]                  chs_led_n_o
);

  logic                    press;   // one pulse per accepted button press
  bmc_sensor_pkg::health_t health;

  button_debouncer button_debouncer_inst (
    .gclk40     (gclk40),
    .hard_reset (hard_reset),
    .button_n_i (chs_powerdown_n_i),
    .press_o    (press)
  );

  level_checker level_checker_inst (
    .gclk40     (gclk40),
    .hard_reset (hard_reset),
    .sample_i   (adc_sample_i),
    .health_o   (health)
  );

  power_manager power_manager_inst (
    .gclk40           (gclk40),
    .hard_reset       (hard_reset),
    .press_i          (press),
    .health_i         (health),
    .atx_pwr_ok_i     (atx_pwr_ok_i),
    .atx_ps_on_n_o    (atx_ps_on_n_o),
    .power_ok_o       (power_ok_o),
    .no_power_cause_o (no_power_cause_o),
    .chs_led_n_o      (chs_led_n_o)
  );

endmodule

//--- tests/power_supervisor_checker.sv
`timescale 1ns/1ps

module power_supervisor_checker (
  input logic                        gclk40,
  input logic                        hard_reset,
  input bmc_sensor_pkg::adc_sample_t adc_sample_i,
  input logic                        atx_pwr_ok_i,
  input logic                        atx_ps_on_n_o,
  input logic                        power_ok_o,
  input bmc_power_pkg::power_cause_t no_power_cause_o,
  input logic [1:0]                  chs_led_n_o
);

  int unsigned fail_count = 0;  // read by the testbench at the end of the run

  logic [$clog2(bmc_sensor_pkg::NUM_CHANNELS)-1:0] ch;
  logic        checked;
  logic        hard_sample;
  logic        soft_sample;
  int unsigned starting_cycles;

  assign ch      = adc_sample_i.channel[$clog2(bmc_sensor_pkg::NUM_CHANNELS)-1:0];
  assign checked = adc_sample_i.strobe &&
                   (adc_sample_i.channel < bmc_sensor_pkg::NUM_CHANNELS);

  assign hard_sample = checked && ((adc_sample_i.result < bmc_sensor_pkg::HARD_LOW[ch]) ||
                                   (adc_sample_i.result > bmc_sensor_pkg::HARD_HIGH[ch]));
  assign soft_sample = checked && !hard_sample &&
                       ((adc_sample_i.result < bmc_sensor_pkg::SOFT_LOW[ch]) ||
                        (adc_sample_i.result > bmc_sensor_pkg::SOFT_HIGH[ch]));

  // cycles with the supply enabled but not yet reported good
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      starting_cycles <= 0;
    end else if (!atx_ps_on_n_o && !power_ok_o) begin
      starting_cycles <= starting_cycles + 1;
    end else begin
      starting_cycles <= 0;
    end
  end

  lamp_test_in_reset: assert property (
    @(posedge gclk40) !hard_reset |=> (chs_led_n_o == 2'b00)
  ) else begin
    fail_count++;
    $error("chs_led_n_o is not 2'b00 while reset is asserted");
  end

  outputs_after_reset: assert property (
    @(posedge gclk40) !hard_reset |=>
      (atx_ps_on_n_o && !power_ok_o && (no_power_cause_o == bmc_power_pkg::CAUSE_NONE))
  ) else begin
    fail_count++;
    $error("supply outputs or cause are not in their reset state");
  end

  // power good needs the supply enabled and reported good one cycle earlier
  power_ok_needs_supply: assert property (
    @(posedge gclk40) disable iff (!hard_reset)
    power_ok_o |-> (!atx_ps_on_n_o && $past(atx_pwr_ok_i))
  ) else begin
    fail_count++;
    $error("power_ok_o is high without an enabled supply that reported good");
  end

  hard_violation_shutdown: assert property (
    @(posedge gclk40) disable iff (!hard_reset)
    (hard_sample && power_ok_o) |-> ##1 power_ok_o ##1
      (!power_ok_o && atx_ps_on_n_o && (no_power_cause_o == bmc_power_pkg::CAUSE_FAULT))
  ) else begin
    fail_count++;
    $error("a hard violation did not shut the supply down two cycles after the strobe");
  end

  soft_violation_led: assert property (
    @(posedge gclk40) disable iff (!hard_reset)
    (soft_sample && power_ok_o) |-> ##2 (power_ok_o && !chs_led_n_o[1])
  ) else begin
    fail_count++;
    $error("a soft violation did not light the action LED with the supply kept on");
  end

  atx_start_bounded: assert property (
    @(posedge gclk40) disable iff (!hard_reset)
    starting_cycles <= bmc_power_pkg::ATX_TIMEOUT + 1
  ) else begin
    fail_count++;
    $error("supply stayed enabled without supply good beyond the ATX timeout");
  end

endmodule

bind power_supervisor power_supervisor_checker checker_inst (
  .gclk40           (gclk40),
  .hard_reset       (hard_reset),
  .adc_sample_i     (adc_sample_i),
  .atx_pwr_ok_i     (atx_pwr_ok_i),
  .atx_ps_on_n_o    (atx_ps_on_n_o),
  .power_ok_o       (power_ok_o),
  .no_power_cause_o (no_power_cause_o),
  .chs_led_n_o      (chs_led_n_o)
);

//--- tests/power_supervisor_tb.sv
`timescale 1ns/1ps

module power_supervisor_tb;

  localparam int SCENARIO_CYCLES = bmc_power_pkg::DEBOUNCE_CYCLES * 3 +
                                   bmc_power_pkg::ATX_TIMEOUT + 20;
  localparam int TIMEOUT_CYCLES  = 4 * 5 * SCENARIO_CYCLES;  // five scenarios
  localparam int PRESS_LIMIT     = 2 * bmc_power_pkg::DEBOUNCE_CYCLES + 8;
  localparam int SETTLE_CYCLES   = bmc_power_pkg::DEBOUNCE_CYCLES + 4;
  localparam int ADC_MAX         = (1 << bmc_sensor_pkg::ADC_WIDTH) - 1;

  logic                        gclk40;
  logic                        hard_reset;
  bmc_sensor_pkg::adc_sample_t adc_sample_i;
  logic                        chs_powerdown_n_i;
  logic                        atx_pwr_ok_i;
  logic                        atx_ps_on_n_o;
  logic                        power_ok_o;
  bmc_power_pkg::power_cause_t no_power_cause_o;
  logic [1:0]                  chs_led_n_o;

  integer seed;
  int     errors;
  int     cycle_count = 0;
  int     starting_len;

  power_supervisor dut (
    .gclk40            (gclk40),
    .hard_reset        (hard_reset),
    .adc_sample_i      (adc_sample_i),
    .chs_powerdown_n_i (chs_powerdown_n_i),
    .atx_pwr_ok_i      (atx_pwr_ok_i),
    .atx_ps_on_n_o     (atx_ps_on_n_o),
    .power_ok_o        (power_ok_o),
    .no_power_cause_o  (no_power_cause_o),
    .chs_led_n_o       (chs_led_n_o)
  );

  initial begin
    gclk40 = 1'b0;
    forever #20 gclk40 = ~gclk40;
  end

  always @(posedge gclk40) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the scenarios did not complete", cycle_count);
      $display("test failed");
      $finish;
    end
  end

  task automatic expect_hex(input string name, input logic [31:0] got,
                            input logic [31:0] want);
    assert (got === want) else begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, want);
      errors++;
    end
  endtask

  task automatic check_ports(input logic ps_on_n, input logic pwr_ok,
                             input bmc_power_pkg::power_cause_t cause);
    expect_hex("atx_ps_on_n_o", atx_ps_on_n_o, ps_on_n);
    expect_hex("power_ok_o", power_ok_o, pwr_ok);
    expect_hex("no_power_cause_o", no_power_cause_o, cause);
  endtask

  function automatic int random_in(input int lo, input int hi);
    int span;
    span = hi - lo + 1;
    return lo + int'($unsigned($random(seed)) % span);
  endfunction

  // kind 0 is in range, 1 a soft violation, 2 a hard violation
  task automatic send_sample(input int ch, input int kind);
    int   lo_hard;
    int   lo_soft;
    int   hi_soft;
    int   hi_hard;
    int   value;
    logic upper;
    lo_hard = bmc_sensor_pkg::HARD_LOW[ch];
    lo_soft = bmc_sensor_pkg::SOFT_LOW[ch];
    hi_soft = bmc_sensor_pkg::SOFT_HIGH[ch];
    hi_hard = bmc_sensor_pkg::HARD_HIGH[ch];
    upper   = (random_in(0, 1) == 1);
    case (kind)
      0: value = random_in(lo_soft, hi_soft);
      1: value = upper ? random_in(hi_soft + 1, hi_hard) : random_in(lo_hard, lo_soft - 1);
      default: value = upper ? random_in(hi_hard + 1, ADC_MAX) : random_in(0, lo_hard - 1);
    endcase
    adc_sample_i.strobe  = 1'b1;
    adc_sample_i.channel = ch[bmc_sensor_pkg::CHANNEL_WIDTH-1:0];
    adc_sample_i.result  = value[bmc_sensor_pkg::ADC_WIDTH-1:0];
    @(negedge gclk40);
    adc_sample_i.strobe = 1'b0;  // one strobe per sample
  endtask

  task automatic rails_good();
    for (int ch = 0; ch < bmc_sensor_pkg::NUM_CHANNELS; ch++) begin
      if (bmc_sensor_pkg::POWERUP_MASK[ch]) begin
        send_sample(ch, 0);
      end
    end
  endtask

  task automatic wait_ps_on(input logic want, input int limit, output int cycles);
    cycles = 0;
    while (atx_ps_on_n_o !== want && cycles < limit) begin
      @(negedge gclk40);
      cycles++;
    end
    if (atx_ps_on_n_o !== want) begin
      $display("atx_ps_on_n_o did not reach %0b within %0d cycles", want, limit);
      errors++;
    end
  endtask

  task automatic press_until(input logic want_ps_on_n);
    int cycles;
    chs_powerdown_n_i = 1'b0;
    wait_ps_on(want_ps_on_n, PRESS_LIMIT, cycles);
    chs_powerdown_n_i = 1'b1;
    repeat (SETTLE_CYCLES) @(negedge gclk40);  // the filter has to see the release
  endtask

  task automatic bounce_button();
    repeat (3) begin
      chs_powerdown_n_i = 1'b0;
      repeat (bmc_power_pkg::DEBOUNCE_CYCLES / 2) @(negedge gclk40);
      chs_powerdown_n_i = 1'b1;
      repeat (2) @(negedge gclk40);
    end
    repeat (SETTLE_CYCLES) @(negedge gclk40);
  endtask

  initial begin
    seed              = 32'h60b0_1702;
    errors            = 0;
    hard_reset        = 1'b0;
    adc_sample_i      = '0;
    chs_powerdown_n_i = 1'b1;
    atx_pwr_ok_i      = 1'b0;

    @(negedge gclk40);
    expect_hex("chs_led_n_o", chs_led_n_o, 2'b00);  // lamp test while in reset
    @(negedge gclk40);
    hard_reset = 1'b1;
    check_ports(1'b1, 1'b0, bmc_power_pkg::CAUSE_NONE);

    rails_good();
    bounce_button();
    expect_hex("atx_ps_on_n_o", atx_ps_on_n_o, 1'b1);  // bounces alone never start the supply
    press_until(1'b0);
    check_ports(1'b0, 1'b0, bmc_power_pkg::CAUSE_NONE);
    atx_pwr_ok_i = 1'b1;
    @(negedge gclk40);
    expect_hex("power_ok_o", power_ok_o, 1'b1);
    expect_hex("chs_led_n_o[0]", chs_led_n_o[0], 1'b0);

    send_sample(4, 1);
    @(negedge gclk40);
    expect_hex("power_ok_o", power_ok_o, 1'b1);
    expect_hex("chs_led_n_o[1]", chs_led_n_o[1], 1'b0);

    send_sample(3, 2);
    expect_hex("power_ok_o", power_ok_o, 1'b1);  // one cycle after the strobe still on
    @(negedge gclk40);
    check_ports(1'b1, 1'b0, bmc_power_pkg::CAUSE_FAULT);

    press_until(1'b0);  // supply good is still high so PWR_ON follows at once
    check_ports(1'b0, 1'b1, bmc_power_pkg::CAUSE_NONE);
    press_until(1'b1);
    check_ports(1'b1, 1'b0, bmc_power_pkg::CAUSE_BUTTON);

    atx_pwr_ok_i      = 1'b0;
    chs_powerdown_n_i = 1'b0;
    wait_ps_on(1'b0, PRESS_LIMIT, starting_len);
    chs_powerdown_n_i = 1'b1;
    check_ports(1'b0, 1'b0, bmc_power_pkg::CAUSE_NONE);
    wait_ps_on(1'b1, bmc_power_pkg::ATX_TIMEOUT + 8, starting_len);
    expect_hex("starting_len", starting_len, bmc_power_pkg::ATX_TIMEOUT);
    check_ports(1'b1, 1'b0, bmc_power_pkg::CAUSE_ATX_FAIL);

    repeat (4) @(negedge gclk40);
    $display("errors: %0d port checks, %0d assertions", errors, dut.checker_inst.fail_count);
    if (errors + dut.checker_inst.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- power_supervisor.f
source/bmc_sensor_pkg.sv
source/bmc_power_pkg.sv
source/button_debouncer.sv
source/level_checker.sv
source/power_manager.sv
source/power_supervisor.sv
tests/power_supervisor_checker.sv
tests/power_supervisor_tb.sv

//--- Bender.yml
package:
  name: power_supervisor

sources:
  # packages first, then the parts and the top level
  - files:
      - source/bmc_sensor_pkg.sv
      - source/bmc_power_pkg.sv
      - source/button_debouncer.sv
      - source/level_checker.sv
      - source/power_manager.sv
      - source/power_supervisor.sv

  - target: test
    files:
      - tests/power_supervisor_checker.sv
      - tests/power_supervisor_tb.sv
